// ==== hw/friscv_cfg.svh ====
`ifndef FRISCV_CFG_SVH
`define FRISCV_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath and buffering sizes of the execution subsystem
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// integer register and ALU width
`define FRISCV_XLEN 32

// program counter width carried along with each instruction
`define FRISCV_ADDRW 16

// entries in the instruction queue between decoder and ALU
`define FRISCV_QUEUE_DEPTH 4

`endif

// ==== hw/friscv_isa_pkg.sv ====
package friscv_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RV32I encodings used by the integer execution path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // register-register arithmetic
        OP_IMM = 7'b0010011,  // register-immediate arithmetic
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    // minor function field, instr[14:12]
    typedef enum logic [2:0] {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,  // funct7 picks logical or arithmetic
        OR      = 3'b110,
        AND     = 3'b111
    } funct3_e;

    // funct7 value that turns ADD into SUB and SRL into SRA
    localparam logic [6:0] funct7_alt = 7'b0100000;

endpackage

// ==== hw/friscv_pipe_pkg.sv ====
`include "friscv_cfg.svh"

package friscv_pipe_pkg;

    // operation carried from the decoder to the ALU
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B  // result is operand B, used by LUI
    } alu_op_e;

    // one decoded instruction as it sits in the queue
    typedef struct packed {
        alu_op_e                  op;
        logic [4:0]               rs1;
        logic [4:0]               rs2;
        logic [4:0]               rd;
        logic                     use_imm;  // operand B from imm instead of rs2
        logic                     use_pc;   // operand A from pc instead of rs1
        logic [`FRISCV_XLEN-1:0]  imm;
        logic [`FRISCV_ADDRW-1:0] pc;
    } alu_instr_t;

endpackage

// ==== hw/friscv_regs_if.sv ====
`include "friscv_cfg.svh"

interface friscv_regs_if;

    logic [4:0]              rs1_addr;
    logic [`FRISCV_XLEN-1:0] rs1_val;   // combinational read data
    logic [4:0]              rs2_addr;
    logic [`FRISCV_XLEN-1:0] rs2_val;
    logic                    wr_en;     // write lands at the next clock edge
    logic [4:0]              wr_addr;
    logic [`FRISCV_XLEN-1:0] wr_data;

    // the ALU side asks for operands and writes results
    modport alu (
        output rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
        input  rs1_val, rs2_val
    );

    // the register file side answers reads and takes writes
    modport regs (
        input  rs1_addr, rs2_addr, wr_en, wr_addr, wr_data,
        output rs1_val, rs2_val
    );

endinterface

// ==== hw/friscv_decoder.sv ====
`include "friscv_cfg.svh"

module friscv_decoder (
    input  logic                        aclk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  logic [31:0]                 instr,
    input  logic [`FRISCV_ADDRW-1:0]    instr_pc,
    input  logic                        queue_full,
    output logic                        push,
    output friscv_pipe_pkg::alu_instr_t entry,
    output logic                        illegal,
    output logic                        ready
);

    friscv_isa_pkg::opcode_e  opcode;
    friscv_isa_pkg::funct3_e  funct3;
    logic                     alt;
    logic [`FRISCV_XLEN-1:0]  imm_i;
    logic [`FRISCV_XLEN-1:0]  imm_u;
    logic                     accept;
    logic                     legal;
    logic                     use_imm;
    logic                     use_pc;
    logic [`FRISCV_XLEN-1:0]  imm;
    friscv_pipe_pkg::alu_op_e op;
    friscv_pipe_pkg::alu_op_e op_f3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field extraction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign opcode = friscv_isa_pkg::opcode_e'(instr[6:0]);
    assign funct3 = friscv_isa_pkg::funct3_e'(instr[14:12]);
    assign alt    = (instr[31:25] == friscv_isa_pkg::funct7_alt);
    assign imm_i  = {{(`FRISCV_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u  = {instr[31:12], 12'h000};

    // a held entry goes into the queue at the next edge, so a new one is only
    // taken when nothing is pending and the queue still has a free slot
    assign ready  = !queue_full && !push;
    assign accept = instr_valid && ready;

    // funct3 to operation, SUB only exists in the register form
    always_comb begin
        case (funct3)
            friscv_isa_pkg::ADD_SUB: begin
                op_f3 = (alt && opcode == friscv_isa_pkg::OP) ? friscv_pipe_pkg::SUB
                                                              : friscv_pipe_pkg::ADD;
            end
            friscv_isa_pkg::SLL:     op_f3 = friscv_pipe_pkg::SLL;
            friscv_isa_pkg::SLT:     op_f3 = friscv_pipe_pkg::SLT;
            friscv_isa_pkg::SLTU:    op_f3 = friscv_pipe_pkg::SLTU;
            friscv_isa_pkg::XOR:     op_f3 = friscv_pipe_pkg::XOR;
            friscv_isa_pkg::SRL_SRA: op_f3 = alt ? friscv_pipe_pkg::SRA : friscv_pipe_pkg::SRL;
            friscv_isa_pkg::OR:      op_f3 = friscv_pipe_pkg::OR;
            default:                 op_f3 = friscv_pipe_pkg::AND;
        endcase
    end

    always_comb begin
        legal   = 1'b1;
        op      = op_f3;
        use_imm = 1'b0;
        use_pc  = 1'b0;
        imm     = imm_i;
        case (opcode)
            friscv_isa_pkg::OP:     use_imm = 1'b0;
            friscv_isa_pkg::OP_IMM: use_imm = 1'b1;  // shift amount sits in imm[4:0]
            friscv_isa_pkg::LUI: begin
                op      = friscv_pipe_pkg::PASS_B;
                use_imm = 1'b1;
                imm     = imm_u;
            end
            friscv_isa_pkg::AUIPC: begin
                op      = friscv_pipe_pkg::ADD;
                use_imm = 1'b1;
                use_pc  = 1'b1;
                imm     = imm_u;
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            push    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            push    <= accept && legal;
            illegal <= accept && !legal;  // one cycle pulse, nothing is queued
        end
    end

    always_ff @(posedge aclk) begin
        if (accept && legal) begin
            entry.op      <= op;
            entry.rs1     <= instr[19:15];
            entry.rs2     <= instr[24:20];
            entry.rd      <= instr[11:7];
            entry.use_imm <= use_imm;
            entry.use_pc  <= use_pc;
            entry.imm     <= imm;
            entry.pc      <= instr_pc;
        end
    end

endmodule

// ==== hw/friscv_inst_queue.sv ====
`include "friscv_cfg.svh"

module friscv_inst_queue #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     aclk,
    input  logic     rst,
    input  logic     push,
    input  payload_t wdata,
    output logic     full,
    input  logic     pop,
    output logic     empty,
    output payload_t rdata
);

    localparam int DEPTH = `FRISCV_QUEUE_DEPTH;
    localparam int PTRW  = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t        mem [DEPTH];
    logic [PTRW-1:0] wr_ptr;
    logic [PTRW-1:0] rd_ptr;
    logic [PTRW:0]   count;
    logic            do_push;
    logic            do_pop;

    function automatic logic [PTRW-1:0] next_ptr(input logic [PTRW-1:0] ptr);
        if (ptr == PTRW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == (PTRW+1)'(DEPTH));
    assign rdata = mem[rd_ptr];  // head is visible right after the push edge

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);  // a full queue still takes a push on a pop

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage holds payload only
    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

endmodule

// ==== hw/friscv_rv32i_alu.sv ====
`include "friscv_cfg.svh"

module friscv_rv32i_alu (
    input  logic                        aclk,
    input  logic                        rst,
    input  logic                        alu_en,
    input  logic                        empty,
    input  friscv_pipe_pkg::alu_instr_t head,
    output logic                        pop,
    friscv_regs_if.alu                  regs,
    output logic                        wb_valid,
    output logic [4:0]                  wb_rd,
    output logic [`FRISCV_XLEN-1:0]     wb_data
);

    logic [`FRISCV_XLEN-1:0] op_a;
    logic [`FRISCV_XLEN-1:0] op_b;
    logic [4:0]              shamt;
    logic [`FRISCV_XLEN-1:0] result;

    // one operation per cycle whenever enabled and work is waiting
    assign pop = alu_en && !empty;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand fetch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign regs.rs1_addr = head.rs1;
    assign regs.rs2_addr = head.rs2;

    // AUIPC adds to the pc, zero extended to the data width
    assign op_a  = head.use_pc ? {{(`FRISCV_XLEN-`FRISCV_ADDRW){1'b0}}, head.pc}
                               : regs.rs1_val;
    assign op_b  = head.use_imm ? head.imm : regs.rs2_val;
    assign shamt = op_b[4:0];  // RV32I shifts only look at five bits

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (head.op)
            friscv_pipe_pkg::ADD:  result = op_a + op_b;
            friscv_pipe_pkg::SUB:  result = op_a - op_b;
            friscv_pipe_pkg::SLL:  result = op_a << shamt;
            friscv_pipe_pkg::SLT: begin
                result = {{(`FRISCV_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            friscv_pipe_pkg::SLTU: begin
                result = {{(`FRISCV_XLEN-1){1'b0}}, (op_a < op_b)};
            end
            friscv_pipe_pkg::XOR:  result = op_a ^ op_b;
            friscv_pipe_pkg::SRL:  result = op_a >> shamt;
            friscv_pipe_pkg::SRA:  result = $unsigned($signed(op_a) >>> shamt);
            friscv_pipe_pkg::OR:   result = op_a | op_b;
            friscv_pipe_pkg::AND:  result = op_a & op_b;
            default:               result = op_b;  // PASS_B for LUI
        endcase
    end

    // write lands at the pop edge, so the next popped entry reads the new value
    assign regs.wr_en   = pop;
    assign regs.wr_addr = head.rd;
    assign regs.wr_data = result;

    always_ff @(posedge aclk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= pop;
        end
    end

    always_ff @(posedge aclk) begin
        if (pop) begin
            wb_rd   <= head.rd;   // reported even for x0
            wb_data <= result;
        end
    end

endmodule

// ==== hw/friscv_regfile.sv ====
`include "friscv_cfg.svh"

module friscv_regfile (
    input  logic        aclk,
    input  logic        rst,
    friscv_regs_if.regs regs
);

    // x0 has no storage
    logic [`FRISCV_XLEN-1:0] x_q [1:31];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read ports, combinational
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign regs.rs1_val = (regs.rs1_addr == 5'd0) ? '0 : x_q[regs.rs1_addr];
    assign regs.rs2_val = (regs.rs2_addr == 5'd0) ? '0 : x_q[regs.rs2_addr];

    // the architectural state starts from zero after reset
    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                x_q[i] <= '0;
            end
        end else if (regs.wr_en && regs.wr_addr != 5'd0) begin
            x_q[regs.wr_addr] <= regs.wr_data;  // writes to x0 are dropped
        end
    end

endmodule

// ==== hw/friscv_exu_top.sv ====
`include "friscv_cfg.svh"

module friscv_exu_top (
    input  logic                     aclk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  logic [31:0]              instr,
    input  logic [`FRISCV_ADDRW-1:0] instr_pc,
    input  logic                     exec_en,
    output logic                     instr_ready,
    output logic                     illegal,
    output logic                     wb_valid,
    output logic [4:0]               wb_rd,
    output logic [`FRISCV_XLEN-1:0]  wb_data
);

    logic                        q_push;
    logic                        q_full;
    logic                        q_pop;
    logic                        q_empty;
    friscv_pipe_pkg::alu_instr_t q_wdata;
    friscv_pipe_pkg::alu_instr_t q_head;

    friscv_regs_if regs_bus ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode, buffer, execute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    friscv_decoder u_decoder (
        .aclk        (aclk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .queue_full  (q_full),
        .push        (q_push),
        .entry       (q_wdata),
        .illegal     (illegal),
        .ready       (instr_ready)
    );

    friscv_inst_queue #(
        .payload_t (friscv_pipe_pkg::alu_instr_t)
    ) u_queue (
        .aclk  (aclk),
        .rst   (rst),
        .push  (q_push),
        .wdata (q_wdata),
        .full  (q_full),
        .pop   (q_pop),
        .empty (q_empty),
        .rdata (q_head)
    );

    friscv_rv32i_alu u_alu (
        .aclk     (aclk),
        .rst      (rst),
        .alu_en   (exec_en),  // level enable, low holds work in the queue
        .empty    (q_empty),
        .head     (q_head),
        .pop      (q_pop),
        .regs     (regs_bus.alu),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    friscv_regfile u_regfile (
        .aclk (aclk),
        .rst  (rst),
        .regs (regs_bus.regs)
    );

endmodule

// ==== verif/friscv_exu_assertions.sv ====
module friscv_exu_assertions (
    input logic        aclk,
    input logic        rst,
    input logic        instr_valid,
    input logic [31:0] instr,
    input logic        instr_ready,
    input logic        exec_en,
    input logic        illegal,
    input logic        wb_valid,
    input logic        q_empty,
    input logic        q_full,
    input logic        q_push
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;  // number of failed checks, watched from the testbench
    logic        legal_op;
    logic        start_ok;

    assign legal_op = instr[6:0] inside {friscv_isa_pkg::OP, friscv_isa_pkg::OP_IMM,
                                         friscv_isa_pkg::LUI, friscv_isa_pkg::AUIPC};

    // a legal instruction taken while nothing is ahead of it
    assign start_ok = instr_valid && instr_ready && legal_op && q_empty && exec_en;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // protocol and timing rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    reset_idle: assert property (@(posedge aclk) rst |=> (!wb_valid && !illegal && instr_ready))
        else begin
            fail_cnt++;
            $error("unit is not idle and ready after reset");
        end

    // decode, queue and execute take one edge each
    latency_3: assert property (@(posedge aclk) disable iff (rst)
        ($past(start_ok, 3) && $past(exec_en)) |-> wb_valid)
        else begin
            fail_cnt++;
            $error("writeback missing three edges after an idle accept");
        end

    stall_quiet: assert property (@(posedge aclk) disable iff (rst) !exec_en |=> !wb_valid)
        else begin
            fail_cnt++;
            $error("writeback while execution is held off");
        end

    // a push onto a full queue is only safe while the ALU frees a slot at the same edge
    no_overflow: assert property (@(posedge aclk) disable iff (rst)
        (q_push && q_full) |-> exec_en)
        else begin
            fail_cnt++;
            $error("instruction pushed into a full queue with execution held off");
        end

endmodule

bind friscv_exu_top friscv_exu_assertions u_checks (
    .aclk        (aclk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .exec_en     (exec_en),
    .illegal     (illegal),
    .wb_valid    (wb_valid),
    .q_empty     (q_empty),
    .q_full      (q_full),
    .q_push      (q_push)
);

// ==== verif/friscv_exu_tb.sv ====
`include "friscv_cfg.svh"

module friscv_exu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 100;  // cycles that any single wait may take
    localparam int IMM_ORDER [9] = '{0, 1, 4, 5, 6, 7, 5, 2, 3};

    logic                     aclk;
    logic                     rst;
    logic                     instr_valid;
    logic [31:0]              instr;
    logic [`FRISCV_ADDRW-1:0] instr_pc;
    logic                     exec_en;
    logic                     instr_ready;
    logic                     illegal;
    logic                     wb_valid;
    logic [4:0]               wb_rd;
    logic [`FRISCV_XLEN-1:0]  wb_data;

    logic [31:0] lfsr;
    logic [31:0] model [32];  // register state as RV32I defines it
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];

    friscv_exu_top dut (.*);

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic wait_ready(input logic level, input string what);
        int waited;
        waited = 0;
        while (instr_ready !== level) begin
            @(negedge aclk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run(what);
            end
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send(input logic [31:0] word);
        instr_valid = 1'b1;
        instr       = word;
        wait_ready(1'b1, "instr_ready did not return while an instruction waited");
        @(negedge aclk);
        instr_valid = 1'b0;
        instr_pc    = instr_pc + 4'd4;
    endtask

    task automatic expect_wb(input logic [4:0] rd, input logic [31:0] value);
        exp_rd.push_back(rd);
        exp_data.push_back(value);
        if (rd != 5'd0) begin
            model[rd] = value;  // x0 keeps reading zero
        end
    endtask

    task automatic op_rr(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [4:0] rs2);
        expect_wb(rd, alu_ref(f3, alt, model[rs1], model[rs2]));
        send({(alt ? 7'h20 : 7'h00), rs2, rs1, f3, rd, friscv_isa_pkg::OP});
    endtask

    task automatic op_ri(input logic [2:0] f3, input logic sra, input logic [4:0] rd,
                         input logic [4:0] rs1, input logic [11:0] imm_in);
        logic [11:0] imm;
        imm = imm_in;
        if (f3 == 3'd1 || f3 == 3'd5) begin
            imm = {(sra ? 7'h20 : 7'h00), imm_in[4:0]};  // shamt form
        end
        expect_wb(rd, alu_ref(f3, sra && f3 == 3'd5, model[rs1], {{20{imm[11]}}, imm}));
        send({imm, rs1, f3, rd, friscv_isa_pkg::OP_IMM});
    endtask

    task automatic op_u(input logic auipc, input logic [4:0] rd, input logic [19:0] upper);
        logic [31:0] base;
        base = auipc ? 32'(instr_pc) : 32'h0;
        expect_wb(rd, {upper, 12'h000} + base);
        send({upper, rd, (auipc ? friscv_isa_pkg::AUIPC : friscv_isa_pkg::LUI)});
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_rd.size() != 0) begin
            @(negedge aclk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("expected writebacks did not arrive in time");
            end
        end
        @(negedge aclk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback checking, in issue order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge aclk) begin : wb_check
        logic [4:0]  rd_exp;
        logic [31:0] data_exp;
        if (dut.u_checks.fail_cnt != 0) begin
            abort_run("a bound protocol assertion failed");
        end else if (!rst && wb_valid) begin
            if (exp_rd.size() == 0) begin
                abort_run("a writeback appeared with no instruction outstanding");
            end else begin
                rd_exp   = exp_rd.pop_front();
                data_exp = exp_data.pop_front();
                if (wb_rd !== rd_exp || wb_data !== data_exp) begin
                    abort_run($sformatf("ERR %0d ns: writeback x%0d = %h, expected x%0d = %h",
                                        $time, wb_rd, wb_data, rd_exp, data_exp));
                end
            end
        end
    end

    initial begin : stimulus
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        int         waited;
        lfsr        = 32'he1bd80d2;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = 16'h0100;
        exec_en     = 1'b1;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (3) @(negedge aclk);
        rst = 1'b0;

        for (int r = 1; r < 9; r++) begin
            op_ri(3'd0, 1'b0, 5'(r), 5'd0, 12'(lfsr_bits(12)));  // addi seeds x1..x8
        end
        drain();

        // every register-register operation, twice over changing sources
        for (int pass = 0; pass < 2; pass++) begin
            for (int f = 0; f < 8; f++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    if (alt == 0 || f == 0 || f == 5) begin
                        rs1 = 5'(lfsr_bits(3)) + 5'd1;
                        rs2 = 5'(lfsr_bits(3)) + 5'd1;
                        rd  = 5'(lfsr_bits(5));
                        op_rr(3'(f), alt == 1, rd, rs1, rs2);
                    end
                end
            end
        end
        drain();

        // dependent chain through x20 with the compares last
        op_u(1'b0, 5'd20, 20'(lfsr_bits(20)));
        for (int i = 0; i < 9; i++) begin
            op_ri(3'(IMM_ORDER[i]), i == 6, 5'd20, 5'd20, 12'(lfsr_bits(12)));
        end
        rd = 5'(lfsr_bits(5));
        op_u(1'b1, rd, 20'(lfsr_bits(20)));
        op_rr(3'd0, 1'b0, 5'd21, 5'd20, rd);
        drain();

        // hold execution until the queue and the decoder stage are full
        exec_en = 1'b0;
        for (int k = 0; k < `FRISCV_QUEUE_DEPTH; k++) begin
            rs1 = 5'(lfsr_bits(3)) + 5'd1;
            op_ri(3'd4, 1'b0, 5'(22 + k), rs1, 12'(lfsr_bits(12)));
        end
        wait_ready(1'b0, "instr_ready stayed high with the queue full");
        // the next instruction waits at the input until the ALU frees a slot
        fork
            op_rr(3'd0, 1'b0, 5'd26, 5'd22, 5'd25);
            begin
                repeat (4) @(negedge aclk);
                exec_en = 1'b1;
            end
        join
        drain();

        send(32'h0000_2083);  // lw x1, 0(x0), not executed here
        waited = 0;
        while (!illegal) begin
            @(negedge aclk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("illegal never pulsed for an unsupported opcode");
            end
        end
        @(negedge aclk);
        if (illegal) begin
            abort_run($sformatf("ERR %0d ns: illegal held for more than one cycle", $time));
        end

        op_ri(3'd0, 1'b0, 5'd0, 5'd1, 12'(lfsr_bits(12)));  // still reported on wb
        op_rr(3'd6, 1'b0, 5'd27, 5'd0, 5'd0);
        drain();

        if (dut.u_checks.fail_cnt != 0) begin
            abort_run("a bound protocol assertion failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== friscv_exu.f ====
+incdir+hw
hw/friscv_isa_pkg.sv
hw/friscv_pipe_pkg.sv
hw/friscv_regs_if.sv
hw/friscv_decoder.sv
hw/friscv_inst_queue.sv
hw/friscv_rv32i_alu.sv
hw/friscv_regfile.sv
hw/friscv_exu_top.sv
verif/friscv_exu_assertions.sv
verif/friscv_exu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= friscv_exu_tb
FLIST     ?= friscv_exu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard hw/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -q '^TEST PASS$$' $(LOG)

check:
	@grep -q '^TEST PASS$$' $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
